/* rtl/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data and address width
`define LSU_XLEN 32

// Byte lanes in one word
`define LSU_BYTES 4

// Address bits that select a lane
`define LSU_OFF_BITS 2

`endif

/* rtl/lsu_pkg.sv */
package lsu_pkg;

`include "lsu_config.svh"

typedef logic [`LSU_XLEN-1:0]  word_t;
typedef logic [`LSU_BYTES-1:0] byte_en_t;
typedef logic [2:0]            funct3_t;

// RV32I major opcodes
typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
} opcode_t;

typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
} load_funct3_t;

typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
} store_funct3_t;

typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
} branch_funct3_t;

typedef enum logic {
    ST_IDLE = 1'b0,
    ST_WAIT = 1'b1
} lsu_state_t;

endpackage

/* rtl/lsu_request_reg.sv */
`timescale 1ns/10ps

module lsu_request_reg import lsu_pkg::*; (
    input  logic    clk,
    input  logic    i_rst_n,

    input  logic    i_valid,
    input  logic    i_busy,
    input  opcode_t i_opcode,
    input  funct3_t i_funct3,
    input  word_t   i_addr,
    input  word_t   i_store_data,

    output logic    o_req_valid,
    output opcode_t o_req_opcode,
    output funct3_t o_req_funct3,
    output word_t   o_req_addr,
    output word_t   o_req_store_data
);

    logic capture;

    // New operation only while the access side is free
    assign capture = i_valid && !i_busy;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_req_valid <= 1'b0;
        end else begin
            o_req_valid <= capture; // One cycle per accepted op
        end
    end

    // Held until the next accepted operation
    always_ff @(posedge clk) begin
        if (capture) begin
            o_req_opcode     <= i_opcode;
            o_req_funct3     <= i_funct3;
            o_req_addr       <= i_addr;
            o_req_store_data <= i_store_data;
        end
    end

endmodule

/* rtl/lsu_access_ctrl.sv */
`timescale 1ns/10ps

`include "lsu_config.svh"

module lsu_access_ctrl import lsu_pkg::*; (
    input  logic                     clk,
    input  logic                     i_rst_n,

    input  logic                     i_req_valid,
    input  opcode_t                  i_req_opcode,
    input  funct3_t                  i_req_funct3,
    input  word_t                    i_req_addr,
    input  word_t                    i_req_store_data,
    input  logic                     i_d_mem_resp,

    output logic                     o_busy,
    output logic                     o_d_mem_read,
    output logic                     o_d_mem_write,
    output word_t                    o_d_mem_addr,
    output word_t                    o_d_mem_wdata,
    output byte_en_t                 o_d_mem_byte_enable,

    output logic                     o_done,
    output logic                     o_trap,
    output byte_en_t                 o_rmask,
    output byte_en_t                 o_wmask,
    output logic                     o_is_load,
    output load_funct3_t             o_load_funct3,
    output logic [`LSU_OFF_BITS-1:0] o_offset,
    output word_t                    o_alu_result
);

    lsu_state_t                state, state_nxt;
    logic [`LSU_OFF_BITS-1:0] offset;
    load_funct3_t             load_f3;
    store_funct3_t            store_f3;
    branch_funct3_t           branch_f3;
    logic                     is_load, is_store;
    logic                     f3_bad, size_trap;
    byte_en_t                 acc_mask;
    logic                     need_acc, active;

    assign offset    = i_req_addr[`LSU_OFF_BITS-1:0];
    assign load_f3   = load_funct3_t'(i_req_funct3);
    assign store_f3  = store_funct3_t'(i_req_funct3);
    assign branch_f3 = branch_funct3_t'(i_req_funct3);
    assign is_load   = (i_req_opcode == op_load);
    assign is_store  = (i_req_opcode == op_store);

    // Lane mask by access size, shared by loads and stores
    always_comb begin
        acc_mask  = '0;
        size_trap = 1'b0;
        case (i_req_funct3[1:0])
            2'b00: acc_mask = 4'b0001 << offset;
            2'b01: begin
                if (offset[0]) begin
                    size_trap = 1'b1; // Odd halfword, no lanes
                end else begin
                    acc_mask = 4'b0011 << offset;
                end
            end
            2'b10: begin
                acc_mask  = 4'b1111 << offset;
                size_trap = (offset != '0);
            end
            default: size_trap = 1'b1;
        endcase
    end

    // Legal funct3 per opcode class
    always_comb begin
        f3_bad = 1'b0;
        case (i_req_opcode)
            op_lui, op_auipc, op_imm, op_reg, op_jal, op_jalr: f3_bad = 1'b0;
            op_br: begin
                case (branch_f3)
                    beq, bne, blt, bge, bltu, bgeu: f3_bad = 1'b0;
                    default: f3_bad = 1'b1;
                endcase
            end
            op_load: begin
                case (load_f3)
                    lb, lh, lw, lbu, lhu: f3_bad = 1'b0;
                    default: f3_bad = 1'b1;
                endcase
            end
            op_store: begin
                case (store_f3)
                    sb, sh, sw: f3_bad = 1'b0;
                    default: f3_bad = 1'b1;
                endcase
            end
            default: f3_bad = 1'b1; // Unknown opcode
        endcase
    end

    assign o_trap  = f3_bad || ((is_load || is_store) && size_trap);
    assign o_rmask = is_load  ? acc_mask : '0;
    assign o_wmask = is_store ? acc_mask : '0;

    assign need_acc = (is_load || is_store) && !o_trap;
    assign active   = i_req_valid || (state == ST_WAIT);

    // Access FSM, strobe level held across the memory wait
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (i_req_valid && need_acc && !i_d_mem_resp) state_nxt = ST_WAIT;
            ST_WAIT: if (i_d_mem_resp) state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_d_mem_read  = active && need_acc && is_load;
    assign o_d_mem_write = active && need_acc && is_store;
    assign o_done        = active && (!need_acc || i_d_mem_resp);
    assign o_busy        = active && !o_done;

    assign o_d_mem_addr        = {i_req_addr[`LSU_XLEN-1:`LSU_OFF_BITS], {`LSU_OFF_BITS{1'b0}}};
    assign o_d_mem_byte_enable = o_wmask;

    // Store data copied into every lane
    always_comb begin
        case (store_f3)
            sb:      o_d_mem_wdata = {4{i_req_store_data[7:0]}};
            sh:      o_d_mem_wdata = {2{i_req_store_data[15:0]}};
            default: o_d_mem_wdata = i_req_store_data;
        endcase
    end

    assign o_is_load     = is_load;
    assign o_load_funct3 = load_f3;
    assign o_offset      = offset;
    assign o_alu_result  = i_req_addr;

endmodule

/* rtl/lsu_load_align.sv */
`timescale 1ns/10ps

`include "lsu_config.svh"

module lsu_load_align import lsu_pkg::*; (
    input  logic                     clk,
    input  logic                     i_rst_n,

    input  logic                     i_done,
    input  logic                     i_trap,
    input  byte_en_t                 i_rmask,
    input  byte_en_t                 i_wmask,
    input  logic                     i_is_load,
    input  load_funct3_t             i_load_funct3,
    input  logic [`LSU_OFF_BITS-1:0] i_offset,
    input  word_t                    i_alu_result,
    input  word_t                    i_d_mem_rdata,

    output logic                     o_wb_valid,
    output word_t                    o_wb_data,
    output logic                     o_wb_trap,
    output byte_en_t                 o_wb_rmask,
    output byte_en_t                 o_wb_wmask
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    word_t       load_data;
    word_t       wb_data_nxt;

    assign lane_byte = i_d_mem_rdata[8*i_offset +: 8];
    assign lane_half = i_d_mem_rdata[16*i_offset[1] +: 16]; // Upper or lower half

    always_comb begin
        case (i_load_funct3)
            lb:      load_data = {{24{lane_byte[7]}}, lane_byte};
            lbu:     load_data = {24'b0, lane_byte};
            lh:      load_data = {{16{lane_half[15]}}, lane_half};
            lhu:     load_data = {16'b0, lane_half};
            lw:      load_data = i_d_mem_rdata;
            default: load_data = '0;
        endcase
    end

    // Store leaves a nonzero wmask, pass-through ops have none
    always_comb begin
        if (i_trap) begin
            wb_data_nxt = '0;
        end else if (i_is_load) begin
            wb_data_nxt = load_data;
        end else if (|i_wmask) begin
            wb_data_nxt = '0;
        end else begin
            wb_data_nxt = i_alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_done;
        end
    end

    always_ff @(posedge clk) begin
        if (i_done) begin
            o_wb_data  <= wb_data_nxt;
            o_wb_trap  <= i_trap;
            o_wb_rmask <= i_rmask;
            o_wb_wmask <= i_wmask;
        end
    end

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/10ps

`include "lsu_config.svh"

module lsu_top import lsu_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,

    input  logic     i_valid,
    input  opcode_t  i_opcode,
    input  funct3_t  i_funct3,
    input  word_t    i_addr,
    input  word_t    i_store_data,
    output logic     o_busy,

    output logic     o_d_mem_read,
    output logic     o_d_mem_write,
    output word_t    o_d_mem_addr,
    output word_t    o_d_mem_wdata,
    output byte_en_t o_d_mem_byte_enable,
    input  logic     i_d_mem_resp,
    input  word_t    i_d_mem_rdata,

    output logic     o_wb_valid,
    output word_t    o_wb_data,
    output logic     o_wb_trap,
    output byte_en_t o_wb_rmask,
    output byte_en_t o_wb_wmask
);

    logic                     req_valid;
    opcode_t                  req_opcode;
    funct3_t                  req_funct3;
    word_t                    req_addr, req_store_data;

    logic                     done, trap, is_load;
    byte_en_t                 rmask, wmask;
    load_funct3_t             load_funct3;
    logic [`LSU_OFF_BITS-1:0] offset;
    word_t                    alu_result;

    lsu_request_reg u_request_reg (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_valid          (i_valid),
        .i_busy           (o_busy),
        .i_opcode         (i_opcode),
        .i_funct3         (i_funct3),
        .i_addr           (i_addr),
        .i_store_data     (i_store_data),
        .o_req_valid      (req_valid),
        .o_req_opcode     (req_opcode),
        .o_req_funct3     (req_funct3),
        .o_req_addr       (req_addr),
        .o_req_store_data (req_store_data)
    );

    lsu_access_ctrl u_access_ctrl (
        .clk                 (clk),
        .i_rst_n             (i_rst_n),
        .i_req_valid         (req_valid),
        .i_req_opcode        (req_opcode),
        .i_req_funct3        (req_funct3),
        .i_req_addr          (req_addr),
        .i_req_store_data    (req_store_data),
        .i_d_mem_resp        (i_d_mem_resp),
        .o_busy              (o_busy),
        .o_d_mem_read        (o_d_mem_read),
        .o_d_mem_write       (o_d_mem_write),
        .o_d_mem_addr        (o_d_mem_addr),
        .o_d_mem_wdata       (o_d_mem_wdata),
        .o_d_mem_byte_enable (o_d_mem_byte_enable),
        .o_done              (done),
        .o_trap              (trap),
        .o_rmask             (rmask),
        .o_wmask             (wmask),
        .o_is_load           (is_load),
        .o_load_funct3       (load_funct3),
        .o_offset            (offset),
        .o_alu_result        (alu_result)
    );

    lsu_load_align u_load_align (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_done        (done),
        .i_trap        (trap),
        .i_rmask       (rmask),
        .i_wmask       (wmask),
        .i_is_load     (is_load),
        .i_load_funct3 (load_funct3),
        .i_offset      (offset),
        .i_alu_result  (alu_result),
        .i_d_mem_rdata (i_d_mem_rdata),
        .o_wb_valid    (o_wb_valid),
        .o_wb_data     (o_wb_data),
        .o_wb_trap     (o_wb_trap),
        .o_wb_rmask    (o_wb_rmask),
        .o_wb_wmask    (o_wb_wmask)
    );

endmodule

/* dv/lsu_clk_gen.sv */
`timescale 1ns/10ps

module lsu_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk; // 10 ns period
    end

    // Reset held over two rising edges, released on a falling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (2) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

/* dv/lsu_checker.sv */
`timescale 1ns/10ps

module lsu_checker import lsu_pkg::*; (
    input logic clk,
    input logic i_rst_n,
    input logic i_busy,
    input logic i_read,
    input logic i_write,
    input logic i_resp
);

    // One access direction at a time
    assert property (@(posedge clk) disable iff (!i_rst_n) !(i_read && i_write))
        else $error("Read and write strobes are high together");

    // Idle right out of reset
    assert property (@(posedge clk) !i_rst_n |=> !i_busy)
        else $error("Busy is high in the cycle after reset");

    assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_read && !i_resp) |=> i_read)
        else $error("Read strobe dropped before the memory response");

    assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_write && !i_resp) |=> i_write)
        else $error("Write strobe dropped before the memory response");

endmodule

/* dv/lsu_tb.sv */
`timescale 1ns/10ps

module lsu_tb import lsu_pkg::*; ();

    localparam word_t      A      = 32'h0000_1000; // Base address of the access rows
    localparam word_t      SD     = 32'hA1B2_C3D4;
    localparam word_t      MEM    = 32'h80F1_7F92;
    localparam word_t      ALU    = 32'h1234_5678;
    localparam logic [1:0] NO_ACC = 2'd0;
    localparam logic [1:0] RD     = 2'd1;
    localparam logic [1:0] WR     = 2'd2;

    typedef struct packed {
        logic [6:0] op;
        funct3_t    f3;
        word_t      addr;
        word_t      sdata;
        word_t      mem;
        word_t      exp_data;
        logic       exp_trap;
        byte_en_t   exp_rmask;
        byte_en_t   exp_wmask;
        logic [1:0] acc;
        byte_en_t   exp_be;
        word_t      exp_wdata;
    } row_t;

    logic clk, i_rst_n;
    logic i_valid, i_d_mem_resp;
    opcode_t i_opcode;
    funct3_t i_funct3;
    word_t i_addr, i_store_data, i_d_mem_rdata;
    logic o_busy, o_d_mem_read, o_d_mem_write, o_wb_valid, o_wb_trap;
    word_t o_d_mem_addr, o_d_mem_wdata, o_wb_data;
    byte_en_t o_d_mem_byte_enable, o_wb_rmask, o_wb_wmask;

    row_t   rows[$];
    int     errors   = 0;
    int     wb_count = 0;
    int     cycles   = 0;
    integer seed;

    lsu_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(i_rst_n));

    lsu_top DUT (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_valid(i_valid), .i_opcode(i_opcode), .i_funct3(i_funct3),
        .i_addr(i_addr), .i_store_data(i_store_data), .o_busy(o_busy),
        .o_d_mem_read(o_d_mem_read), .o_d_mem_write(o_d_mem_write),
        .o_d_mem_addr(o_d_mem_addr), .o_d_mem_wdata(o_d_mem_wdata),
        .o_d_mem_byte_enable(o_d_mem_byte_enable),
        .i_d_mem_resp(i_d_mem_resp), .i_d_mem_rdata(i_d_mem_rdata),
        .o_wb_valid(o_wb_valid), .o_wb_data(o_wb_data), .o_wb_trap(o_wb_trap),
        .o_wb_rmask(o_wb_rmask), .o_wb_wmask(o_wb_wmask)
    );

    bind lsu_access_ctrl lsu_checker u_checker (
        .clk(clk), .i_rst_n(i_rst_n), .i_busy(o_busy),
        .i_read(o_d_mem_read), .i_write(o_d_mem_write), .i_resp(i_d_mem_resp)
    );

    task automatic add_row(input logic [6:0] op, input funct3_t f3, input word_t addr,
                           input word_t sdata, input word_t mem, input word_t data,
                           input logic trap, input byte_en_t rmask, input byte_en_t wmask,
                           input logic [1:0] acc, input byte_en_t be, input word_t wdata);
        rows.push_back({op, f3, addr, sdata, mem, data, trap, rmask, wmask, acc, be, wdata});
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic apply_row(input row_t r);
        int delay;
        @(negedge clk);
        i_valid       = 1'b1;
        i_opcode      = opcode_t'(r.op);
        i_funct3      = r.f3;
        i_addr        = r.addr;
        i_store_data  = r.sdata;
        i_d_mem_rdata = ~r.mem; // Stale bus data until a response
        @(negedge clk);
        i_valid = 1'b0; // Request now registered
        check_value("o_d_mem_read", 32'(o_d_mem_read), 32'(r.acc == RD));
        check_value("o_d_mem_write", 32'(o_d_mem_write), 32'(r.acc == WR));
        if (r.acc != NO_ACC) begin
            check_value("o_d_mem_addr", o_d_mem_addr, {r.addr[31:2], 2'b00});
            check_value("o_d_mem_byte_enable", 32'(o_d_mem_byte_enable), 32'(r.exp_be));
            if (r.acc == WR) begin
                check_value("o_d_mem_wdata", o_d_mem_wdata, r.exp_wdata);
            end
            delay = int'($unsigned($random(seed)) % 4);
            repeat (delay) begin
                check_value("o_busy", 32'(o_busy), 32'd1);
                i_valid  = 1'b1; // Must be ignored while busy
                i_opcode = op_imm;
                i_addr   = 32'hDEAD_BEEF;
                @(negedge clk);
            end
            i_valid       = 1'b0;
            i_d_mem_resp  = 1'b1;
            i_d_mem_rdata = r.mem;
            @(negedge clk);
            i_d_mem_resp  = 1'b0;
            i_d_mem_rdata = 32'h0;
        end else begin
            check_value("o_busy", 32'(o_busy), 32'd0);
            @(negedge clk);
        end
        while (!o_wb_valid) @(negedge clk);
        check_value("o_wb_data", o_wb_data, r.exp_data);
        check_value("o_wb_trap", 32'(o_wb_trap), 32'(r.exp_trap));
        check_value("o_wb_rmask", 32'(o_wb_rmask), 32'(r.exp_rmask));
        check_value("o_wb_wmask", 32'(o_wb_wmask), 32'(r.exp_wmask));
        @(negedge clk);
        check_value("o_wb_valid", 32'(o_wb_valid), 32'd0); // Single-cycle pulse
    endtask

    always @(negedge clk) begin
        if (i_rst_n && o_wb_valid) begin
            wb_count <= wb_count + 1;
        end
    end

    // Each row needs well under 20 cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 20 * rows.size()) begin
            $display("Timeout: run did not finish within %0d cycles", cycles);
            $display("Summary: %0d rows, %0d errors", rows.size(), errors);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        seed          = 50;
        i_valid       = 1'b0;
        i_opcode      = op_imm;
        i_funct3      = 3'd0;
        i_addr        = 32'h0;
        i_store_data  = 32'h0;
        i_d_mem_resp  = 1'b0;
        i_d_mem_rdata = 32'h0;

        // Loads at every legal offset
        add_row(op_load, 3'd0, A+0, SD, MEM, 32'hFFFF_FF92, 0, 4'b0001, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd0, A+1, SD, MEM, 32'h0000_007F, 0, 4'b0010, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd0, A+2, SD, MEM, 32'hFFFF_FFF1, 0, 4'b0100, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd0, A+3, SD, MEM, 32'hFFFF_FF80, 0, 4'b1000, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd4, A+0, SD, MEM, 32'h0000_0092, 0, 4'b0001, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd4, A+1, SD, MEM, 32'h0000_007F, 0, 4'b0010, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd4, A+2, SD, MEM, 32'h0000_00F1, 0, 4'b0100, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd4, A+3, SD, MEM, 32'h0000_0080, 0, 4'b1000, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd1, A+0, SD, MEM, 32'h0000_7F92, 0, 4'b0011, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd1, A+2, SD, MEM, 32'hFFFF_80F1, 0, 4'b1100, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd5, A+0, SD, MEM, 32'h0000_7F92, 0, 4'b0011, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd5, A+2, SD, MEM, 32'h0000_80F1, 0, 4'b1100, 4'b0, RD, 4'b0, 0);
        add_row(op_load, 3'd2, A+0, SD, MEM, 32'h80F1_7F92, 0, 4'b1111, 4'b0, RD, 4'b0, 0);
        // Stores with data copied into every lane
        add_row(op_store, 3'd0, A+0, SD, MEM, 0, 0, 4'b0, 4'b0001, WR, 4'b0001, 32'hD4D4_D4D4);
        add_row(op_store, 3'd0, A+1, SD, MEM, 0, 0, 4'b0, 4'b0010, WR, 4'b0010, 32'hD4D4_D4D4);
        add_row(op_store, 3'd0, A+2, SD, MEM, 0, 0, 4'b0, 4'b0100, WR, 4'b0100, 32'hD4D4_D4D4);
        add_row(op_store, 3'd0, A+3, SD, MEM, 0, 0, 4'b0, 4'b1000, WR, 4'b1000, 32'hD4D4_D4D4);
        add_row(op_store, 3'd1, A+0, SD, MEM, 0, 0, 4'b0, 4'b0011, WR, 4'b0011, 32'hC3D4_C3D4);
        add_row(op_store, 3'd1, A+2, SD, MEM, 0, 0, 4'b0, 4'b1100, WR, 4'b1100, 32'hC3D4_C3D4);
        add_row(op_store, 3'd2, A+0, SD, MEM, 0, 0, 4'b0, 4'b1111, WR, 4'b1111, 32'hA1B2_C3D4);
        // Misaligned and undefined funct3 trap without an access
        add_row(op_load,  3'd2, A+1, SD, MEM, 0, 1, 4'b1110, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_load,  3'd2, A+2, SD, MEM, 0, 1, 4'b1100, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_load,  3'd2, A+3, SD, MEM, 0, 1, 4'b1000, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_store, 3'd2, A+1, SD, MEM, 0, 1, 4'b0, 4'b1110, NO_ACC, 4'b0, 0);
        add_row(op_store, 3'd2, A+2, SD, MEM, 0, 1, 4'b0, 4'b1100, NO_ACC, 4'b0, 0);
        add_row(op_load,  3'd1, A+1, SD, MEM, 0, 1, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_load,  3'd1, A+3, SD, MEM, 0, 1, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_store, 3'd1, A+1, SD, MEM, 0, 1, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_store, 3'd1, A+3, SD, MEM, 0, 1, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_load,  3'd3, A+0, SD, MEM, 0, 1, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_store, 3'd3, A+0, SD, MEM, 0, 1, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        // Pass-through, illegal branch and unknown opcode
        add_row(op_lui,   3'd0, ALU, SD, MEM, ALU, 0, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_auipc, 3'd3, ALU, SD, MEM, ALU, 0, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_jal,   3'd0, ALU, SD, MEM, ALU, 0, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_jalr,  3'd0, ALU, SD, MEM, ALU, 0, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_imm,   3'd6, ALU, SD, MEM, ALU, 0, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_reg,   3'd7, ALU, SD, MEM, ALU, 0, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_br,    3'd1, ALU, SD, MEM, ALU, 0, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_br,    3'd2, ALU, SD, MEM, 0, 1, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(op_br,    3'd3, ALU, SD, MEM, 0, 1, 4'b0, 4'b0, NO_ACC, 4'b0, 0);
        add_row(7'h7F,    3'd0, ALU, SD, MEM, 0, 1, 4'b0, 4'b0, NO_ACC, 4'b0, 0);

        wait (i_rst_n === 1'b1);
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        repeat (2) @(negedge clk);
        check_value("wb_valid pulse count", 32'(wb_count), 32'(rows.size()));
        $display("Summary: %0d rows, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_request_reg.sv
rtl/lsu_access_ctrl.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
dv/lsu_clk_gen.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module lsu_tb -f list.f -o lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/lsu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
